// File: flist.f
morse_pkg.sv
morse_keyer.sv
morse_decoder.sv
message_buffer.sv
matrix_scan.sv
morse_display_top.sv
tb_morse_display.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the Morse display testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f \
	--top-module tb_morse_display \
	-o sim_tb

# The exit status of tee is kept so the log can be inspected below
./obj_dir/sim_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "Simulation failed"
	exit 1
fi

if ! grep -q "=== PASS ===" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi

echo "Simulation passed"

// File: tb_morse_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_morse_display import morse_pkg::*; ();

	localparam int HOLD_CYCLES = 4;
	localparam int SCROLL_CYCLES = 200;
	localparam int SCAN_CYCLES = 2;
	localparam int DEPTH = 3;
	localparam int N_ENTRIES = 6;
	localparam int HELD_IDX = DEPTH; // First entry that finds the buffer full
	localparam int MAX_PAUSE = 8;
	localparam int CAPTURE_CYCLES = 2 * MATRIX_SIZE * SCAN_CYCLES + 1;
	localparam int KEY_SHORT = 0;
	localparam int KEY_LONG = 1;
	localparam int KEY_CHAR = 2;
	localparam int KEY_SHOW = 3;
	localparam int SEG_A = 0;
	localparam int SEG_C = 2;
	localparam int SEG_D = 3;
	localparam int SEG_E = 4;
	localparam int SEG_F = 5;
	localparam int SEG_G = 6;

	logic clk;
	logic reset;
	logic short_key;
	logic long_key;
	logic char_key;
	logic show_key;
	logic [6:0] seg;
	matrix_drive_t matrix;

	string sym_tab [N_ENTRIES];
	logic [6:0] seg_tab [N_ENTRIES][MAX_SYMBOLS];
	char_code_t code_tab [N_ENTRIES];
	logic [63:0] glyph_tab [N_ENTRIES]; // Line 0 in the top byte

	int error_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	morse_display_top #(
		.HOLD_CYCLES(HOLD_CYCLES),
		.SCROLL_CYCLES(SCROLL_CYCLES),
		.SCAN_CYCLES(SCAN_CYCLES),
		.DEPTH(DEPTH)
	) u_morse_display_top (
		.clk(clk),
		.reset(reset),
		.short_key(short_key),
		.long_key(long_key),
		.char_key(char_key),
		.show_key(show_key),
		.seg(seg),
		.matrix(matrix)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_run();
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: the run took more than %0d cycles", cycle_limit);
			stop_run();
		end
	end

	// Active-low digit built from the lit segments of S or L
	function automatic logic [6:0] seg_for_symbol(input byte c);
		logic [6:0] lit;
		lit = '0;
		if (c == "S") begin
			lit[SEG_A] = 1'b1;
			lit[SEG_C] = 1'b1;
			lit[SEG_D] = 1'b1;
			lit[SEG_F] = 1'b1;
			lit[SEG_G] = 1'b1;
		end else begin
			lit[SEG_D] = 1'b1;
			lit[SEG_E] = 1'b1;
			lit[SEG_F] = 1'b1;
		end
		return ~lit;
	endfunction

	task automatic add_entry(input int i, input string syms, input char_code_t code,
			input logic [63:0] glyph);
		sym_tab[i] = syms;
		code_tab[i] = code;
		glyph_tab[i] = glyph;
		for (int k = 0; k < syms.len(); k++) begin
			seg_tab[i][k] = seg_for_symbol(syms[k]);
		end
	endtask

	task automatic load_table();
		add_entry(0, "SL", 6'd1, 64'h38_44_44_44_7C_44_44_00); // A
		add_entry(1, "LLLSL", 6'd0, 64'h00_00_00_00_00_00_00_00); // Unknown pattern
		add_entry(2, "SSSSL", 6'd30, 64'h44_44_44_7C_04_04_04_00); // Digit 4
		add_entry(3, "LSL", 6'd11, 64'h44_48_50_60_50_48_44_00); // K, held back
		add_entry(4, "LLSS", 6'd26, 64'h7C_04_08_10_20_40_7C_00); // Z
		add_entry(5, "SLLLL", 6'd27, 64'h10_30_10_10_10_10_10_00); // Digit 1
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
			error_count++;
			stop_run();
		end
	endtask

	// Drive one key low for a single cycle
	task automatic press_key(input int which);
		case (which)
			KEY_SHORT: short_key = 1'b0;
			KEY_LONG: long_key = 1'b0;
			KEY_CHAR: char_key = 1'b0;
			default: show_key = 1'b0;
		endcase
		@(negedge clk);
		short_key = 1'b1;
		long_key = 1'b1;
		char_key = 1'b1;
		show_key = 1'b1;
	endtask

	// One full scan with each col sample stored under the row that is low
	task automatic capture_glyph(output logic [63:0] lines);
		logic [7:0] seen;
		int idx;
		lines = '0;
		seen = '0;
		for (int n = 0; n < CAPTURE_CYCLES; n++) begin
			@(negedge clk);
			for (int b = 0; b < MATRIX_SIZE; b++) begin
				if (!matrix.row[b]) begin
					idx = MATRIX_SIZE - 1 - b;
					lines[63 - 8 * idx -: 8] = matrix.col;
					seen[idx] = 1'b1;
				end
			end
		end
		assert (seen == 8'hFF) else begin
			$display("Matrix scan did not reach every row within one full scan");
			error_count++;
			stop_run();
		end
	endtask

	task automatic check_char(input logic [63:0] exp_glyph, input char_code_t exp_code);
		logic [63:0] got;
		capture_glyph(got);
		check_value("matrix.col glyph", got, exp_glyph);
		check_value("show_code", 64'(u_morse_display_top.show_code), 64'(exp_code));
	endtask

	task automatic key_character(input int i);
		for (int k = 0; k < sym_tab[i].len(); k++) begin
			press_key(sym_tab[i][k] == "S" ? KEY_SHORT : KEY_LONG);
			check_value("seg", 64'(seg), 64'(seg_tab[i][k]));
			repeat (HOLD_CYCLES + 2) @(negedge clk);
		end
		press_key(KEY_CHAR);
		repeat (HOLD_CYCLES + 10) @(negedge clk);
	endtask

	// Four windows checked in their middle and wrapping back to the first
	task automatic check_scroll(input int first);
		int entry;
		press_key(KEY_SHOW);
		for (int w = 0; w < 4; w++) begin
			entry = first + (w % DEPTH);
			repeat (SCROLL_CYCLES / 2 - CAPTURE_CYCLES / 2) @(negedge clk);
			check_char(glyph_tab[entry], code_tab[entry]);
			repeat (SCROLL_CYCLES / 2 + CAPTURE_CYCLES / 2 - CAPTURE_CYCLES) @(negedge clk);
		end
	endtask

	initial begin
		int total;
		int pause;
		void'($urandom(32'hc48015bb));
		reset = 1'b0;
		short_key = 1'b1;
		long_key = 1'b1;
		char_key = 1'b1;
		show_key = 1'b1;
		load_table();
		total = 8 + CAPTURE_CYCLES;
		for (int i = 0; i < N_ENTRIES; i++) begin
			total += (sym_tab[i].len() + 1) * (HOLD_CYCLES + 3) + HOLD_CYCLES + 10;
			total += CAPTURE_CYCLES + MAX_PAUSE;
		end
		total += HOLD_CYCLES + 10 + SCROLL_CYCLES + 20 + 2 * CAPTURE_CYCLES;
		total += 4 * SCROLL_CYCLES + 1;
		cycle_limit = 4 * total;

		repeat (8) @(negedge clk);
		reset = 1'b1;
		check_value("seg", 64'(seg), 64'h7F);
		check_char(64'h0, 6'd0);

		for (int i = 0; i < N_ENTRIES; i++) begin
			pause = int'($urandom % MAX_PAUSE);
			repeat (pause) @(negedge clk);
			key_character(i);
			if (i == HELD_IDX) begin
				check_char(glyph_tab[i - 1], code_tab[i - 1]); // Full buffer keeps the last one
				check_value("code_valid", 64'(u_morse_display_top.code_valid), 64'h1);
				press_key(KEY_SHOW); // Scroll lets the held code in
				repeat (HOLD_CYCLES + 10) @(negedge clk);
				check_char(glyph_tab[i], code_tab[i]);
				repeat (SCROLL_CYCLES + 20) @(negedge clk);
				check_char(glyph_tab[i], code_tab[i]); // Back in store mode
			end else begin
				check_char(glyph_tab[i], code_tab[i]);
			end
		end

		check_scroll(HELD_IDX);

		if (error_count == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

`default_nettype wire

// File: morse_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module morse_display_top import morse_pkg::*; #(
	parameter int unsigned HOLD_CYCLES = 1_000_000,
	parameter int unsigned SCROLL_CYCLES = 50_000_000,
	parameter int unsigned SCAN_CYCLES = 100,
	parameter int unsigned DEPTH = 21
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic short_key,
	input wire logic long_key,
	input wire logic char_key,
	input wire logic show_key,
	output logic [6:0] seg,
	output matrix_drive_t matrix
);

	pattern_t pattern;
	logic pattern_valid;
	logic pattern_ready;
	char_code_t code;
	logic code_valid;
	logic code_ready;
	char_code_t show_code;

	morse_keyer #(
		.HOLD_CYCLES(HOLD_CYCLES)
	) u_morse_keyer (
		.clk(clk),
		.reset(reset),
		.short_key(short_key),
		.long_key(long_key),
		.char_key(char_key),
		.pattern(pattern),
		.pattern_valid(pattern_valid),
		.pattern_ready(pattern_ready),
		.seg(seg)
	);

	morse_decoder u_morse_decoder (
		.clk(clk),
		.reset(reset),
		.pattern(pattern),
		.pattern_valid(pattern_valid),
		.pattern_ready(pattern_ready),
		.code(code),
		.code_valid(code_valid),
		.code_ready(code_ready)
	);

	message_buffer #(
		.DEPTH(DEPTH),
		.SCROLL_CYCLES(SCROLL_CYCLES)
	) u_message_buffer (
		.clk(clk),
		.reset(reset),
		.code(code),
		.code_valid(code_valid),
		.code_ready(code_ready),
		.show_key(show_key),
		.show_code(show_code)
	);

	matrix_scan #(
		.SCAN_CYCLES(SCAN_CYCLES)
	) u_matrix_scan (
		.clk(clk),
		.reset(reset),
		.show_code(show_code),
		.matrix(matrix)
	);

endmodule

`default_nettype wire

// File: matrix_scan.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_scan import morse_pkg::*; #(
	parameter int unsigned SCAN_CYCLES = 100
) (
	input wire logic clk,
	input wire logic reset,
	input wire char_code_t show_code,
	output matrix_drive_t matrix
);

	localparam int GLYPH_LINES = MATRIX_SIZE - 1; // Bottom line stays dark
	localparam int IDX_W = $clog2(MATRIX_SIZE);
	localparam int DWELL_W = $clog2(SCAN_CYCLES + 1);

	typedef matrix_line_t [0:GLYPH_LINES-1] glyph_t; // Line 0 is the top row

	function automatic glyph_t glyph_of(input char_code_t c);
		case (c)
			6'd1: return 56'h38_44_44_44_7C_44_44; // A
			6'd2: return 56'h78_44_44_78_44_44_78;
			6'd3: return 56'h38_44_40_40_40_44_38;
			6'd4: return 56'h78_44_44_44_44_44_78;
			6'd5: return 56'h7C_40_40_78_40_40_7C;
			6'd6: return 56'h7C_40_40_78_40_40_40;
			6'd7: return 56'h38_44_40_40_5C_44_38;
			6'd8: return 56'h44_44_44_7C_44_44_44;
			6'd9: return 56'h38_10_10_10_10_10_38;
			6'd10: return 56'h04_04_04_04_44_44_38;
			6'd11: return 56'h44_48_50_60_50_48_44;
			6'd12: return 56'h40_40_40_40_40_40_7E; // L is one column wider
			6'd13: return 56'h44_6C_54_44_44_44_44;
			6'd14: return 56'h44_44_64_54_4C_44_44;
			6'd15: return 56'h38_44_44_44_44_44_38;
			6'd16: return 56'h78_44_44_44_78_40_40;
			6'd17: return 56'h38_44_44_44_54_4C_3C;
			6'd18: return 56'h78_44_44_44_78_44_44;
			6'd19: return 56'h38_44_40_38_04_44_38;
			6'd20: return 56'h7C_10_10_10_10_10_10;
			6'd21: return 56'h44_44_44_44_44_44_38;
			6'd22: return 56'h44_44_44_44_44_28_10;
			6'd23: return 56'h44_44_44_44_54_6C_44;
			6'd24: return 56'h44_44_28_10_28_44_44;
			6'd25: return 56'h44_44_44_28_10_10_10;
			6'd26: return 56'h7C_04_08_10_20_40_7C; // Z
			6'd27: return 56'h10_30_10_10_10_10_10; // Digit 1
			6'd28: return 56'h7C_04_04_7C_40_40_7C;
			6'd29: return 56'h7C_04_04_3C_04_04_7C;
			6'd30: return 56'h44_44_44_7C_04_04_04;
			6'd31: return 56'h7C_40_40_7C_04_04_7C;
			6'd32: return 56'h7C_40_40_7C_44_44_7C;
			6'd33: return 56'h7C_04_04_08_10_10_10;
			6'd34: return 56'h7C_44_44_7C_44_44_7C;
			6'd35: return 56'h7C_44_44_7C_04_04_7C;
			6'd36: return 56'h7C_44_44_44_44_44_7C; // Digit 0
			default: return '0;
		endcase
	endfunction

	logic [DWELL_W-1:0] dwell;
	logic [IDX_W-1:0] row_idx;
	glyph_t glyph;
	matrix_line_t line;

	assign glyph = glyph_of(show_code);
	assign line = (row_idx < IDX_W'(GLYPH_LINES)) ? glyph[row_idx] : '0;

	always_ff @(posedge clk) begin
		if (!reset) begin
			dwell <= '0;
			row_idx <= '0;
		end else if (dwell == DWELL_W'(SCAN_CYCLES - 1)) begin
			dwell <= '0;
			row_idx <= row_idx + 1'b1; // Wraps after the last row
		end else begin
			dwell <= dwell + 1'b1;
		end
	end

	// Row and col registered together so they stay paired
	always_ff @(posedge clk) begin
		if (!reset) begin
			matrix.row <= ~(matrix_line_t'(1) << (MATRIX_SIZE - 1));
			matrix.col <= '0;
		end else begin
			matrix.row <= ~(matrix_line_t'(1) << (MATRIX_SIZE - 1 - int'(row_idx)));
			matrix.col <= line;
		end
	end

	a_row_onehot: assert property (
		@(posedge clk) disable iff (!reset)
		$onehot(~matrix.row)
	);

endmodule

`default_nettype wire

// File: message_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module message_buffer import morse_pkg::*; #(
	parameter int unsigned DEPTH = 21,
	parameter int unsigned SCROLL_CYCLES = 50_000_000
) (
	input wire logic clk,
	input wire logic reset,
	input wire char_code_t code,
	input wire logic code_valid,
	output logic code_ready,
	input wire logic show_key, // Active low
	output char_code_t show_code
);

	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int TMR_W = $clog2(SCROLL_CYCLES + 1);

	char_code_t mem [DEPTH];
	logic [CNT_W-1:0] wr_count;
	logic [CNT_W-1:0] rd_idx;
	logic [CNT_W-1:0] rd_next;
	logic [CNT_W-1:0] wr_addr;
	logic [TMR_W-1:0] scroll_tmr;
	logic scroll; // 0 store mode, 1 scroll mode
	logic xfer;

	assign code_ready = scroll || (wr_count != CNT_W'(DEPTH));
	assign xfer = code_valid && code_ready;
	assign wr_addr = scroll ? '0 : wr_count; // New entry restarts the message
	assign rd_next = (rd_idx + 1'b1 < wr_count) ? rd_idx + 1'b1 : '0;

	always_ff @(posedge clk) begin
		if (xfer) begin
			mem[wr_addr] <= code;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			wr_count <= '0;
			rd_idx <= '0;
			scroll_tmr <= '0;
			scroll <= 1'b0;
			show_code <= CODE_BLANK;
		end else if (xfer) begin
			wr_count <= wr_addr + 1'b1;
			show_code <= code;
			scroll <= 1'b0;
		end else if (!scroll) begin
			if (!show_key && wr_count != '0) begin
				scroll <= 1'b1;
				rd_idx <= '0;
				scroll_tmr <= '0;
				show_code <= mem[0];
			end
		end else if (scroll_tmr == TMR_W'(SCROLL_CYCLES - 1)) begin
			scroll_tmr <= '0;
			rd_idx <= rd_next;
			show_code <= mem[rd_next];
		end else begin
			scroll_tmr <= scroll_tmr + 1'b1;
		end
	end

	a_count_bound: assert property (
		@(posedge clk) disable iff (!reset)
		wr_count <= CNT_W'(DEPTH)
	);

endmodule

`default_nettype wire

// File: morse_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module morse_decoder import morse_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire pattern_t pattern,
	input wire logic pattern_valid,
	output logic pattern_ready,
	output char_code_t code,
	output logic code_valid,
	input wire logic code_ready
);

	localparam symbol_t S = SYM_SHORT;
	localparam symbol_t L = SYM_LONG;
	localparam symbol_t N = SYM_NONE;

	function automatic char_code_t decode(input pattern_t p);
		case (p.sym)
			{S, L, N, N, N}: return 6'd1; // A
			{L, S, S, S, N}: return 6'd2;
			{L, S, L, S, N}: return 6'd3;
			{L, S, S, N, N}: return 6'd4;
			{S, N, N, N, N}: return 6'd5; // E
			{S, S, L, S, N}: return 6'd6;
			{L, L, S, N, N}: return 6'd7;
			{S, S, S, S, N}: return 6'd8;
			{S, S, N, N, N}: return 6'd9;
			{S, L, L, L, N}: return 6'd10;
			{L, S, L, N, N}: return 6'd11;
			{S, L, S, S, N}: return 6'd12;
			{L, L, N, N, N}: return 6'd13;
			{L, S, N, N, N}: return 6'd14; // N
			{L, L, L, N, N}: return 6'd15;
			{S, L, L, S, N}: return 6'd16;
			{L, L, S, L, N}: return 6'd17;
			{S, L, S, N, N}: return 6'd18;
			{S, S, S, N, N}: return 6'd19;
			{L, N, N, N, N}: return 6'd20; // T
			{S, S, L, N, N}: return 6'd21;
			{S, S, S, L, N}: return 6'd22;
			{S, L, L, N, N}: return 6'd23;
			{L, S, S, L, N}: return 6'd24;
			{L, S, L, L, N}: return 6'd25;
			{L, L, S, S, N}: return 6'd26; // Z
			{S, L, L, L, L}: return 6'd27; // Digit 1
			{S, S, L, L, L}: return 6'd28;
			{S, S, S, L, L}: return 6'd29;
			{S, S, S, S, L}: return 6'd30;
			{S, S, S, S, S}: return 6'd31;
			{L, S, S, S, S}: return 6'd32;
			{L, L, S, S, S}: return 6'd33;
			{L, L, L, S, S}: return 6'd34;
			{L, L, L, L, S}: return 6'd35;
			{L, L, L, L, L}: return 6'd36; // Digit 0
			default: return CODE_BLANK;
		endcase
	endfunction

	logic take;

	assign pattern_ready = !code_valid || code_ready;
	assign take = pattern_valid && pattern_ready;

	always_ff @(posedge clk) begin
		if (!reset) begin
			code_valid <= 1'b0;
		end else if (take) begin
			code_valid <= 1'b1;
		end else if (code_ready) begin
			code_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			code <= decode(pattern);
		end
	end

	// Output stage holds while the buffer stalls
	a_code_stable: assert property (
		@(posedge clk) disable iff (!reset)
		code_valid && !code_ready |=> code_valid && $stable(code)
	);

endmodule

`default_nettype wire

// File: morse_keyer.sv
`timescale 1ns/1ps
`default_nettype none

module morse_keyer import morse_pkg::*; #(
	parameter int unsigned HOLD_CYCLES = 1_000_000
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic short_key, // Active low
	input wire logic long_key,
	input wire logic char_key,
	output pattern_t pattern,
	output logic pattern_valid,
	input wire logic pattern_ready,
	output logic [6:0] seg
);

	localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);
	localparam int FILL_W = $clog2(MAX_SYMBOLS + 1);
	localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(HOLD_CYCLES - 1);

	localparam logic [6:0] SEG_S = 7'b0010010;
	localparam logic [6:0] SEG_L = 7'b1000111;
	localparam logic [6:0] SEG_OFF = 7'b1111111;

	typedef enum logic [1:0] {
		KEY_IDLE,
		KEY_LOCKOUT,
		KEY_PENDING
	} key_state_t;

	key_state_t state;
	logic [HOLD_W-1:0] hold_cnt;
	logic [FILL_W-1:0] fill; // Fields used so far
	logic char_end; // Lockout was started by char_key
	symbol_t key_sym;
	logic sym_press;

	assign sym_press = !short_key || !long_key;
	assign key_sym = !short_key ? SYM_SHORT : SYM_LONG; // Short wins a tie
	assign pattern_valid = (state == KEY_PENDING);

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= KEY_IDLE;
			hold_cnt <= '0;
			fill <= '0;
			char_end <= 1'b0;
			pattern <= '0;
			seg <= SEG_OFF;
		end else begin
			case (state)
				KEY_IDLE: begin
					if (sym_press) begin
						if (fill < FILL_W'(MAX_SYMBOLS)) begin
							pattern.sym[MAX_SYMBOLS - 1 - int'(fill)] <= key_sym;
							fill <= fill + 1'b1;
						end
						seg <= (key_sym == SYM_SHORT) ? SEG_S : SEG_L; // Shown even if dropped
						hold_cnt <= HOLD_LOAD;
						char_end <= 1'b0;
						state <= KEY_LOCKOUT;
					end else if (!char_key) begin
						hold_cnt <= HOLD_LOAD;
						char_end <= 1'b1;
						state <= KEY_LOCKOUT;
					end
				end
				KEY_LOCKOUT: begin
					if (hold_cnt == '0) begin
						state <= char_end ? KEY_PENDING : KEY_IDLE;
					end else begin
						hold_cnt <= hold_cnt - 1'b1;
					end
				end
				KEY_PENDING: begin
					if (pattern_ready) begin // Transfer this cycle
						pattern <= '0;
						fill <= '0;
						state <= KEY_IDLE;
					end
				end
				default: state <= KEY_IDLE;
			endcase
		end
	end

	// Held pattern must not change under back-pressure
	a_pattern_stable: assert property (
		@(posedge clk) disable iff (!reset)
		pattern_valid && !pattern_ready |=> pattern_valid && $stable(pattern)
	);

endmodule

`default_nettype wire

// File: morse_pkg.sv
`default_nettype none

package morse_pkg;

	localparam int MAX_SYMBOLS = 5; // Most symbols in one character
	localparam int MATRIX_SIZE = 8;
	localparam int CODE_W = 6;

	typedef enum logic [1:0] {
		SYM_NONE = 2'b00,
		SYM_SHORT = 2'b01,
		SYM_LONG = 2'b10
	} symbol_t;

	// sym[MAX_SYMBOLS-1] holds the first symbol keyed
	typedef struct packed {
		symbol_t [MAX_SYMBOLS-1:0] sym;
	} pattern_t;

	typedef logic [CODE_W-1:0] char_code_t; // 1-26 A-Z, 27-35 digits 1-9, 36 zero

	localparam char_code_t CODE_BLANK = '0;

	typedef logic [MATRIX_SIZE-1:0] matrix_line_t;

	typedef struct packed {
		matrix_line_t col; // Active high
		matrix_line_t row; // Active-low one-hot
	} matrix_drive_t;

endpackage

`default_nettype wire
